// ==== rtl/plant_defines.svh ====
`ifndef PLANT_DEFINES_SVH
`define PLANT_DEFINES_SVH

// Command word
`define WORD_BITS 64

// CLK cycles per SCK period, half low and half high
`define SCK_DIV 4

// Duty measurement window in CLK cycles
`define PWM_WINDOW 256

`define COIL_STEP 16  // Current change per cycle
`define COIL_MAX 4095  // Saturation magnitude

// Encoder counter length, half a phase period
`define ENC_DIV 16

`endif

// ==== rtl/plant_pkg.sv ====
`default_nettype none

package plant_pkg;

  typedef struct packed {
    logic sck;
    logic cs;  // Active low
    logic copi;
  } spi_bus_t;

  typedef struct packed {
    logic low_1;
    logic high_1;
    logic low_2;
    logic high_2;
  } coil_drive_t;

  typedef enum logic [1:0] {
    COAST,
    FORWARD,
    REVERSE,
    BRAKE
  } coil_mode_e;

  typedef enum logic [1:0] {
    WAIT_BOOT,
    IDLE,
    SHIFT
  } sender_state_e;

  typedef logic signed [12:0] current_t;
  typedef logic [11:0] duty_t;  // Same scale as current magnitude

endpackage

`default_nettype wire

// ==== rtl/spi_word_sender.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "plant_defines.svh"

module spi_word_sender (
  input  wire                   CLK,
  input  wire                   resetn,
  input  wire                   boot_done,
  input  wire [`WORD_BITS-1:0]  word_in,
  input  wire                   word_start,
  output logic                  word_busy,
  output logic                  word_done,
  output plant_pkg::spi_bus_t   spi
);
  import plant_pkg::*;

  localparam int PH_W  = $clog2(`SCK_DIV);
  localparam int BIT_W = $clog2(`WORD_BITS);
  localparam logic [PH_W-1:0]  PH_LAST  = PH_W'(`SCK_DIV - 1);
  localparam logic [PH_W-1:0]  PH_HIGH  = PH_W'(`SCK_DIV / 2);
  localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`WORD_BITS - 1);

  sender_state_e          state;
  logic [PH_W-1:0]        phase;
  logic [BIT_W-1:0]       bit_cnt;
  logic [`WORD_BITS-1:0]  shreg;
  logic [7:0]             byte_next;
  logic                   copi_r;
  logic                   shifting;

  assign shifting  = (state == SHIFT);
  assign byte_next = {shreg[6:0], shreg[7]};  // Rotate current byte, MSB out first
  assign word_busy = shifting;

  // Mode 0, sck idles low, cs low only while shifting
  assign spi = '{sck: shifting && (phase >= PH_HIGH), cs: !shifting, copi: copi_r};

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state     <= WAIT_BOOT;
      phase     <= '0;
      bit_cnt   <= '0;
      copi_r    <= 1'b0;
      word_done <= 1'b0;
    end else begin
      word_done <= 1'b0;
      case (state)
        WAIT_BOOT: begin
          if (boot_done) begin
            state <= IDLE;  // Boot seen once, never waits again
          end
        end
        IDLE: begin
          if (word_start) begin
            state   <= SHIFT;
            phase   <= '0;
            bit_cnt <= '0;
          end
        end
        SHIFT: begin
          phase <= phase + 1'b1;
          if (phase == '0) begin
            copi_r <= shreg[7];  // One cycle ahead of sck rise
          end
          if (phase == PH_LAST) begin
            phase   <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == BIT_LAST) begin
              state     <= IDLE;
              word_done <= 1'b1;
            end
          end
        end
        default: state <= WAIT_BOOT;
      endcase
    end
  end

  // After the 8th rotation the byte is intact again and moves to the top
  always_ff @(posedge CLK) begin
    if (state == IDLE && word_start) begin
      shreg <= word_in;
    end else if (shifting && phase == '0) begin
      if (bit_cnt[2:0] == 3'd7) begin
        shreg <= {byte_next, shreg[`WORD_BITS-1:8]};
      end else begin
        shreg[7:0] <= byte_next;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/pwm_duty.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "plant_defines.svh"

module pwm_duty (
  input  wire               CLK,
  input  wire               resetn,
  input  wire               pwm,
  output plant_pkg::duty_t  duty
);
  import plant_pkg::*;

  localparam int WIN_W = $clog2(`PWM_WINDOW);
  localparam logic [WIN_W-1:0] WIN_LAST = WIN_W'(`PWM_WINDOW - 1);

  logic [WIN_W-1:0] win_cnt;
  logic [WIN_W:0]   high_cnt;
  logic [WIN_W:0]   total;
  logic [WIN_W+4:0] scaled;
  duty_t            capped;

  assign total  = high_cnt + {{WIN_W{1'b0}}, pwm};  // Includes this cycle
  assign scaled = {total, 4'b0000};  // 16 per high cycle
  assign capped = (|scaled[WIN_W+4:12]) ? '1 : scaled[11:0];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      win_cnt  <= '0;
      high_cnt <= '0;
      duty     <= '0;
    end else begin
      win_cnt <= win_cnt + 1'b1;
      if (win_cnt == WIN_LAST) begin
        duty     <= capped;
        high_cnt <= '0;
      end else begin
        high_cnt <= total;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/hbridge_coil.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "plant_defines.svh"

module hbridge_coil #(
  parameter bit POLARITY_INVERT = 1'b0
) (
  input  wire                     CLK,
  input  wire                     resetn,
  input  wire plant_pkg::coil_drive_t drive,
  output plant_pkg::current_t     current
);
  import plant_pkg::*;

  localparam logic signed [13:0] STEP = 14'sd`COIL_STEP;
  localparam current_t CUR_MAX = 13'sd`COIL_MAX;
  localparam current_t CUR_MIN = -13'sd`COIL_MAX;

  coil_mode_e          mode;
  logic signed [13:0]  cur_ext;
  logic signed [13:0]  delta;
  logic signed [13:0]  sum;

  always_comb begin
    if (drive.high_1 && drive.low_2) begin
      mode = FORWARD;
    end else if (drive.high_2 && drive.low_1) begin
      mode = REVERSE;
    end else if (drive.low_1 && drive.low_2) begin
      mode = BRAKE;  // Both low sides shorting the coil
    end else begin
      mode = COAST;
    end
  end

  always_comb begin
    cur_ext = current;  // Sign extended, room for overflow
    case (mode)
      FORWARD: delta = POLARITY_INVERT ? -STEP : STEP;
      REVERSE: delta = POLARITY_INVERT ? STEP : -STEP;
      BRAKE: begin
        if (cur_ext > STEP) begin
          delta = -STEP;
        end else if (cur_ext < -STEP) begin
          delta = STEP;
        end else begin
          delta = -cur_ext;  // Snap to zero
        end
      end
      default: delta = '0;
    endcase
    sum = cur_ext + delta;
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      current <= '0;
    end else if (sum > CUR_MAX) begin
      current <= CUR_MAX;
    end else if (sum < CUR_MIN) begin
      current <= CUR_MIN;
    end else begin
      current <= sum[12:0];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/current_comparator.sv ====
`timescale 1ns/1ps
`default_nettype none

module current_comparator (
  input  wire                     CLK,
  input  wire                     resetn,
  input  wire plant_pkg::current_t current,
  input  wire plant_pkg::duty_t   target,
  output logic                    cmp
);
  import plant_pkg::*;

  current_t mag;

  // Saturation keeps the current off -4096, so the negation fits
  assign mag = current[12] ? -current : current;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      cmp <= 1'b1;
    end else begin
      cmp <= (mag[11:0] >= target);  // Unsigned compare
    end
  end

endmodule

`default_nettype wire

// ==== rtl/quad_encoder_gen.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "plant_defines.svh"

module quad_encoder_gen (
  input  wire   CLK,
  input  wire   resetn,
  output logic  enc_a,
  output logic  enc_b
);

  localparam int CNT_W = $clog2(`ENC_DIV);
  localparam logic [CNT_W-1:0] A_FLIP = CNT_W'(`ENC_DIV - 1);
  localparam logic [CNT_W-1:0] B_FLIP = CNT_W'(`ENC_DIV / 2 - 1);  // Quarter period later

  logic [CNT_W-1:0] cnt;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      cnt   <= '0;
      enc_a <= 1'b0;
      enc_b <= 1'b1;
    end else begin
      cnt <= cnt + 1'b1;
      if (cnt == A_FLIP) begin
        enc_a <= ~enc_a;
      end
      if (cnt == B_FLIP) begin
        enc_b <= ~enc_b;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/rapcore_harness.sv ====
`timescale 1ns/1ps
`default_nettype none

module rapcore_harness (
  input  wire                         CLK,
  input  wire                         resetn,
  input  wire                         boot_done,
  input  wire [63:0]                  word_in,
  input  wire                         word_start,
  output logic                        word_busy,
  output logic                        word_done,
  output plant_pkg::spi_bus_t         spi,
  input  wire plant_pkg::coil_drive_t coil_a,
  input  wire plant_pkg::coil_drive_t coil_b,
  input  wire                         analog_out1,
  input  wire                         analog_out2,
  output logic                        analog_cmp1,
  output logic                        analog_cmp2,
  output logic                        enc_a,
  output logic                        enc_b
);
  import plant_pkg::*;

  current_t current1;
  current_t current2;
  duty_t    target1;
  duty_t    target2;

  spi_word_sender sender (
    .CLK(CLK), .resetn(resetn), .boot_done(boot_done), .word_in(word_in),
    .word_start(word_start), .word_busy(word_busy), .word_done(word_done), .spi(spi)
  );

  hbridge_coil #(.POLARITY_INVERT(1'b0)) coil1 (
    .CLK(CLK), .resetn(resetn), .drive(coil_a), .current(current1)
  );
  hbridge_coil #(.POLARITY_INVERT(1'b0)) coil2 (
    .CLK(CLK), .resetn(resetn), .drive(coil_b), .current(current2)
  );

  pwm_duty duty1 (.CLK(CLK), .resetn(resetn), .pwm(analog_out1), .duty(target1));
  pwm_duty duty2 (.CLK(CLK), .resetn(resetn), .pwm(analog_out2), .duty(target2));

  current_comparator cmp1 (
    .CLK(CLK), .resetn(resetn), .current(current1), .target(target1), .cmp(analog_cmp1)
  );
  current_comparator cmp2 (
    .CLK(CLK), .resetn(resetn), .current(current2), .target(target2), .cmp(analog_cmp2)
  );

  quad_encoder_gen encoder (.CLK(CLK), .resetn(resetn), .enc_a(enc_a), .enc_b(enc_b));

endmodule

`default_nettype wire

// ==== verification/harness_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module harness_checker (
  input  wire                      CLK,
  input  wire                      resetn,
  input  wire plant_pkg::spi_bus_t spi,
  input  wire                      word_busy,
  input  wire                      word_done,
  input  wire                      analog_cmp1,
  input  wire                      analog_cmp2,
  input  wire                      enc_a,
  input  wire                      enc_b,
  input  wire                      boot_ok,
  input  wire [63:0]               exp_word,
  input  wire                      exp_cmp1,
  input  wire                      exp_cmp2,
  input  wire [1:0]                exp_enc,
  input  wire [7:0]                test_num,
  input  wire                      test_end,
  output int                       errors,
  output int                       passed,
  output int                       failed
);

  logic [63:0] rebuilt;
  int          bits;
  int          test_errors;
  logic        sck_prev;
  logic        cs_prev;

  task automatic mismatch(input string name, input logic [63:0] got, input logic [63:0] want);
    $display("FAILED %s: got %0h, expected %0h at %0d ns", name, got, want, $time);
    errors++;
    test_errors++;
  endtask

  task automatic fault(input string what);
    $display("Error: %s at %0d ns", what, $time);
    errors++;
    test_errors++;
  endtask

  // Sampled mid-cycle when outputs are stable
  always @(negedge CLK) begin
    if (!resetn) begin
      errors = 0;
      passed = 0;
      failed = 0;
      test_errors = 0;
      bits = 0;
      sck_prev = 1'b0;
      cs_prev = 1'b1;
    end else begin
      if (!boot_ok && (!spi.cs || word_done)) fault("SPI activity before boot_done");
      if (word_busy !== !spi.cs) mismatch("word_busy", word_busy, !spi.cs);
      if (spi.sck && !sck_prev && !spi.cs) begin
        if (bits < 64) begin
          rebuilt[(bits / 8) * 8 + 7 - bits % 8] = spi.copi;  // Byte 0 first and MSB first
        end
        bits++;
      end
      if (spi.cs && !cs_prev) begin
        if (bits != 64) mismatch("sck rising edges", bits, 64);
        if (rebuilt !== exp_word) mismatch("spi word", rebuilt, exp_word);
        if (!word_done) fault("cs rose without word_done");
        bits = 0;
      end else if (word_done) begin
        fault("word_done outside the end of a word");
      end
      if (analog_cmp1 !== exp_cmp1) mismatch("analog_cmp1", analog_cmp1, exp_cmp1);
      if (analog_cmp2 !== exp_cmp2) mismatch("analog_cmp2", analog_cmp2, exp_cmp2);
      if ({enc_a, enc_b} !== exp_enc) mismatch("enc_a/enc_b", {enc_a, enc_b}, exp_enc);
      if (test_end) begin
        if (test_errors == 0) begin
          $display("test %0d passed", test_num);
          passed++;
        end else begin
          $display("test %0d failed with %0d errors", test_num, test_errors);
          failed++;
        end
        test_errors = 0;
      end
      sck_prev = spi.sck;
      cs_prev = spi.cs;
    end
  end

endmodule

`default_nettype wire

// ==== verification/harness_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "plant_defines.svh"

module harness_tb;
  import plant_pkg::*;

  typedef struct packed {
    logic [63:0] word;
    coil_mode_e  mode_a;
    coil_mode_e  mode_b;
    int          high;  // PWM high cycles per window
    int          wait_len;
  } stim_t;

  localparam int NUM_TESTS = 6;
  localparam logic [1:0] ENC_SEQ [4] = '{2'b01, 2'b00, 2'b10, 2'b11};  // {enc_a, enc_b}

  logic        CLK = 1'b0;
  logic        resetn, boot_done, boot_ok, word_start, word_busy, word_done;
  logic [63:0] word_in, exp_word;
  spi_bus_t    spi;
  coil_drive_t coil_a, coil_b;
  coil_mode_e  mode_a, mode_b;
  logic        analog_out1, analog_out2, analog_cmp1, analog_cmp2, enc_a, enc_b;
  logic        exp_cmp1, exp_cmp2, test_end, limit_ready;
  logic [1:0]  exp_enc;
  logic [7:0]  test_num;
  int          cur_a, cur_b, duty1, duty2, hi1, hi2, win, pwm_cnt, pwm_high, enc_ticks;
  int          errors, passed, failed, limit;
  stim_t       tbl [NUM_TESTS];

  always #5 CLK = ~CLK;

  rapcore_harness DUT (.*);
  harness_checker check (.*);

  assign exp_enc = ENC_SEQ[(enc_ticks / (`ENC_DIV / 2)) % 4];  // One step per half counter

  function automatic coil_drive_t drive_for(coil_mode_e m);
    case (m)
      FORWARD: return '{low_1: 1'b0, high_1: 1'b1, low_2: 1'b1, high_2: 1'b0};
      REVERSE: return '{low_1: 1'b1, high_1: 1'b0, low_2: 1'b0, high_2: 1'b1};
      BRAKE:   return '{low_1: 1'b1, high_1: 1'b0, low_2: 1'b1, high_2: 1'b0};
      default: return '0;  // All switches open
    endcase
  endfunction

  function automatic int coil_next(int cur, coil_mode_e m);
    int nxt;
    case (m)
      FORWARD: nxt = cur + `COIL_STEP;
      REVERSE: nxt = cur - `COIL_STEP;
      BRAKE:   nxt = (cur > `COIL_STEP) ? cur - `COIL_STEP :
                     (cur < -`COIL_STEP) ? cur + `COIL_STEP : 0;
      default: nxt = cur;
    endcase
    return (nxt > `COIL_MAX) ? `COIL_MAX : (nxt < -`COIL_MAX) ? -`COIL_MAX : nxt;
  endfunction

  function automatic int duty_of(int high);
    return (high * 16 > 4095) ? 4095 : high * 16;
  endfunction

  // Reference models and PWM sources, same edge as the DUT registers
  always @(posedge CLK) begin
    if (!resetn) begin
      cur_a <= 0;
      cur_b <= 0;
      duty1 <= 0;
      duty2 <= 0;
      hi1 <= 0;
      hi2 <= 0;
      win <= 0;
      pwm_cnt <= 0;
      enc_ticks <= 0;
      exp_cmp1 <= 1'b1;
      exp_cmp2 <= 1'b1;
      analog_out1 <= 1'b0;
      analog_out2 <= 1'b0;
    end else begin
      cur_a <= coil_next(cur_a, mode_a);
      cur_b <= coil_next(cur_b, mode_b);
      win <= (win == `PWM_WINDOW - 1) ? 0 : win + 1;
      hi1 <= (win == `PWM_WINDOW - 1) ? 0 : hi1 + analog_out1;
      hi2 <= (win == `PWM_WINDOW - 1) ? 0 : hi2 + analog_out2;
      if (win == `PWM_WINDOW - 1) begin
        duty1 <= duty_of(hi1 + analog_out1);  // Last cycle of the window counts
        duty2 <= duty_of(hi2 + analog_out2);
      end
      exp_cmp1 <= ((cur_a < 0) ? -cur_a : cur_a) >= duty1;
      exp_cmp2 <= ((cur_b < 0) ? -cur_b : cur_b) >= duty2;
      enc_ticks <= enc_ticks + 1;
      pwm_cnt <= (pwm_cnt + 1) % `PWM_WINDOW;
      analog_out1 <= (pwm_cnt < pwm_high);
      analog_out2 <= (pwm_cnt < pwm_high / 2);  // Half the duty on channel 2
    end
  end

  task automatic end_test(input int n);
    test_num <= 8'(n);
    test_end <= 1'b1;
    @(posedge CLK);
    test_end <= 1'b0;
  endtask

  initial begin
    void'($urandom(74757));
    resetn = 1'b0;
    boot_done = 1'b0;
    boot_ok = 1'b0;
    word_in = '0;
    exp_word = '0;
    word_start = 1'b0;
    coil_a = '0;
    coil_b = '0;
    mode_a = COAST;
    mode_b = COAST;
    analog_out1 = 1'b0;
    analog_out2 = 1'b0;
    pwm_high = 0;
    test_num = '0;
    test_end = 1'b0;
    limit_ready = 1'b0;
    tbl[0] = '{64'h0a000000000000ff, FORWARD, REVERSE, 40, 600};
    tbl[1] = '{64'h01000000000000aa, COAST, BRAKE, 100, 500};
    tbl[2] = '{64'h00000000005fffff, BRAKE, COAST, 20, 400};
    tbl[3] = '{64'hd000000000000000, REVERSE, FORWARD, 256, 600};
    tbl[4] = '{{$urandom, $urandom}, COAST, COAST, 128, 300};
    tbl[5] = '{{$urandom, $urandom}, BRAKE, REVERSE, 0, 400};
    limit = 2 * `PWM_WINDOW + 20 + 300 + 2000;
    foreach (tbl[i]) limit += tbl[i].wait_len + 300;
    limit_ready = 1'b1;
    repeat (8) @(posedge CLK);
    resetn <= 1'b1;
    @(posedge CLK);
    word_in <= tbl[0].word;  // Sent before boot, must be ignored
    pwm_high <= tbl[0].high;
    word_start <= 1'b1;
    @(posedge CLK);
    word_start <= 1'b0;
    repeat (2 * `PWM_WINDOW) @(posedge CLK);  // Duty settles before the coil charges
    end_test(0);
    boot_done <= 1'b1;
    boot_ok <= 1'b1;
    for (int i = 0; i < NUM_TESTS; i++) begin
      @(posedge CLK);
      word_in <= tbl[i].word;
      exp_word <= tbl[i].word;
      word_start <= 1'b1;
      mode_a <= tbl[i].mode_a;
      mode_b <= tbl[i].mode_b;
      coil_a <= drive_for(tbl[i].mode_a);
      coil_b <= drive_for(tbl[i].mode_b);
      pwm_high <= tbl[i].high;
      @(posedge CLK);
      word_start <= 1'b0;
      do @(negedge CLK); while (!word_done);
      repeat (tbl[i].wait_len) @(posedge CLK);
      end_test(i + 1);
    end
    @(posedge CLK);
    $display("%0d tests: %0d passed, %0d failed, %0d errors",
             passed + failed, passed, failed, errors);
    if (errors == 0 && failed == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    wait (limit_ready);
    repeat (limit) @(posedge CLK);
    $display("Timeout after %0d cycles, the DUT did not finish all words", limit);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+rtl
rtl/plant_pkg.sv
rtl/spi_word_sender.sv
rtl/pwm_duty.sv
rtl/hbridge_coil.sv
rtl/current_comparator.sv
rtl/quad_encoder_gen.sv
rtl/rapcore_harness.sv
verification/harness_checker.sv
verification/harness_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f --top-module harness_tb -o harness_sim
./obj_dir/harness_sim | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi
echo "Simulation finished without failures"
